//--- rtl/msx_bus_pkg.sv
package msx_bus_pkg;

   // one cpu access as presented on the bus port
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        is_io;
      logic        is_write;
      logic        is_m1;
      logic        spare;
   } cpu_cycle_t;

   // access towards the external memory, already resolved to a slot
   typedef struct packed {
      logic [1:0]  slot;
      logic [1:0]  page;
      logic [13:0] offset;
      logic [7:0]  wdata;
      logic        write;
   } mem_req_t;

   // psg access, reg_sel is address bit 0
   typedef struct packed {
      logic       reg_sel;
      logic       write;
      logic [7:0] data;
   } psg_req_t;

   // a7..a3 of the i/o address
   localparam logic [4:0] PSG_PORT_HI  = 5'b10100;
   localparam logic [4:0] PPI_PORT_HI  = 5'b10101;

   // floating data bus reads back as all ones
   localparam logic [7:0] IO_IDLE_DATA = 8'hFF;

endpackage

//--- rtl/msx_cfg_pkg.sv
package msx_cfg_pkg;

   typedef logic [1:0] slot_t;
   typedef logic [1:0] page_t;

   // four 16k pages in the cpu map
   localparam int PAGE_COUNT = 4;

   // audio path widths
   localparam int PSG_LEVEL_W = 10;
   localparam int CART_W      = 16;
   localparam int MIX_W       = 17;

   // clip levels of the output sample
   localparam logic [15:0] AUDIO_MAX = 16'h7FFF;
   localparam logic [15:0] AUDIO_MIN = 16'h8000;

   // key click and tape monitor levels, in psg units
   localparam int BEEP_WEIGHT = 32;
   localparam int CAS_WEIGHT  = 16;

endpackage

//--- rtl/msx_hs_initiator.sv
`timescale 1ns/1ps

module msx_hs_initiator #(
   parameter type req_t = logic [7:0]
) (
   input  logic       clk21m,
   input  logic       exwait_n,
   input  logic       start_i,
   input  req_t       payload_i,
   input  logic [7:0] rdata_i,
   output logic       req_o,
   output req_t       payload_o,
   input  logic       ack_i,
   output logic       done_o,
   output logic [7:0] rdata_o
);

   typedef enum logic [1:0] {
      HS_IDLE,
      HS_REQ,
      HS_DROP
   } hs_state_t;

   hs_state_t state;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         state <= HS_IDLE;
         req_o <= 1'b0;
      end else begin
         case (state)
            HS_IDLE: begin
               if (start_i) begin
                  req_o <= 1'b1;
                  state <= HS_REQ;
               end
            end
            HS_REQ: begin
               // target has taken the cycle
               if (ack_i) begin
                  req_o <= 1'b0;
                  state <= HS_DROP;
               end
            end
            HS_DROP: begin
               if (!ack_i)
                  state <= HS_IDLE;
            end
            default: state <= HS_IDLE;
         endcase
      end
   end

   // payload held for the whole request, read data caught with ack
   always_ff @(posedge clk21m) begin
      if (state == HS_IDLE && start_i)
         payload_o <= payload_i;
      if (state == HS_REQ && ack_i)
         rdata_o <= rdata_i;
   end

   // finished once the target has released ack
   assign done_o = (state == HS_DROP) && !ack_i;

endmodule

//--- rtl/msx_bus_ctrl.sv
`timescale 1ns/1ps

module msx_bus_ctrl (
   input  logic                    clk21m,
   input  logic                    exwait_n,
   input  logic                    cpu_req_i,
   input  msx_bus_pkg::cpu_cycle_t cpu_cycle_i,
   output logic                    cpu_ack_o,
   output logic [7:0]              cpu_rdata_o,
   output msx_bus_pkg::cpu_cycle_t cycle_o,
   output logic                    io_stb_o,
   input  logic [7:0]              io_rdata_i,
   output logic                    mem_start_o,
   output logic                    psg_start_o,
   input  logic                    done_i,
   input  logic [7:0]              ext_rdata_i
);
   import msx_bus_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WAIT,
      ST_DISPATCH,
      ST_HOLD,
      ST_RELEASE
   } state_t;

   state_t state;
   logic   psg_cycle;

   // psg ports leave the core, every other port is answered here
   assign psg_cycle   = cycle_o.is_io && (cycle_o.addr[7:3] == PSG_PORT_HI);
   assign io_stb_o    = (state == ST_DISPATCH) && cycle_o.is_io && !psg_cycle;
   assign psg_start_o = (state == ST_DISPATCH) && psg_cycle;
   assign mem_start_o = (state == ST_DISPATCH) && !cycle_o.is_io;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         state     <= ST_IDLE;
         cpu_ack_o <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cpu_req_i) begin
                  // opcode fetch gets one extra cycle like the z80 wait circuit
                  if (cpu_cycle_i.is_m1 && !cpu_cycle_i.is_io)
                     state <= ST_WAIT;
                  else
                     state <= ST_DISPATCH;
               end
            end
            ST_WAIT: state <= ST_DISPATCH;
            ST_DISPATCH: begin
               if (io_stb_o) begin
                  cpu_ack_o <= 1'b1;
                  state     <= ST_RELEASE;
               end else begin
                  state <= ST_HOLD;
               end
            end
            ST_HOLD: begin
               if (done_i) begin
                  cpu_ack_o <= 1'b1;
                  state     <= ST_RELEASE;
               end
            end
            ST_RELEASE: begin
               if (!cpu_req_i) begin
                  cpu_ack_o <= 1'b0;
                  state     <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk21m) begin
      if (state == ST_IDLE && cpu_req_i)
         cycle_o <= cpu_cycle_i;
      if (io_stb_o)
         cpu_rdata_o <= io_rdata_i;
      else if (state == ST_HOLD && done_i)
         cpu_rdata_o <= ext_rdata_i;
   end

endmodule

//--- rtl/msx_io_decode.sv
`timescale 1ns/1ps

module msx_io_decode (
   input  msx_bus_pkg::cpu_cycle_t cycle_i,
   input  logic                    io_stb_i,
   input  logic [7:0]              ppi_rdata_i,
   output logic                    ppi_wr_o,
   output logic [1:0]              ppi_sel_o,
   output logic                    psg_hit_o,
   output logic [7:0]              io_rdata_o
);
   import msx_bus_pkg::*;

   logic ppi_hit;

   // a8..af, the ppi mirrors on a1..a0
   assign ppi_hit   = cycle_i.is_io && (cycle_i.addr[7:3] == PPI_PORT_HI);
   // a0..a7
   assign psg_hit_o = cycle_i.is_io && (cycle_i.addr[7:3] == PSG_PORT_HI);

   assign ppi_sel_o = cycle_i.addr[1:0];
   assign ppi_wr_o  = io_stb_i && ppi_hit && cycle_i.is_write;

   // nothing else answers on the internal i/o bus
   assign io_rdata_o = ppi_hit ? ppi_rdata_i : IO_IDLE_DATA;

endmodule

//--- rtl/msx_ppi.sv
`timescale 1ns/1ps

module msx_ppi (
   input  logic       clk21m,
   input  logic       exwait_n,
   input  logic [1:0] sel_i,
   input  logic       wr_i,
   input  logic [7:0] wdata_i,
   input  logic [7:0] kb_cols_i,
   output logic [7:0] rdata_o,
   output logic [7:0] slot_reg_o,
   output logic       map_valid_o,
   output logic [3:0] kb_row_o,
   output logic       cas_motor_o,
   output logic       keybeep_o
);
   import msx_bus_pkg::*;

   logic [7:0] port_c;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         slot_reg_o  <= '0;
         port_c      <= '0;
         map_valid_o <= 1'b0;
      end else if (wr_i) begin
         case (sel_i)
            2'd0: begin
               slot_reg_o  <= wdata_i;
               map_valid_o <= 1'b1;
            end
            2'd2: port_c <= wdata_i;
            2'd3: begin
               // bit set/reset only, mode words are dropped
               if (!wdata_i[7])
                  port_c[wdata_i[3:1]] <= wdata_i[0];
            end
            // port b is an input
            default: ;
         endcase
      end
   end

   always_comb begin
      case (sel_i)
         2'd0:    rdata_o = slot_reg_o;
         2'd1:    rdata_o = kb_cols_i;
         2'd2:    rdata_o = port_c;
         default: rdata_o = IO_IDLE_DATA;
      endcase
   end

   // port c: row select low nibble, motor bit 4, click bit 7
   assign kb_row_o    = port_c[3:0];
   assign cas_motor_o = port_c[4];
   assign keybeep_o   = port_c[7];

endmodule

//--- rtl/msx_slot_map.sv
`timescale 1ns/1ps

module msx_slot_map (
   input  msx_bus_pkg::cpu_cycle_t cycle_i,
   input  logic [7:0]              slot_reg_i,
   input  logic                    map_valid_i,
   output msx_bus_pkg::mem_req_t   mem_req_o
);
   import msx_bus_pkg::*;
   import msx_cfg_pkg::*;

   page_t page;
   slot_t slot;

   assign page = cycle_i.addr[15:14];

   // slot 0 everywhere until the slot register has been written
   always_comb begin
      slot = '0;
      if (map_valid_i) begin
         for (int p = 0; p < PAGE_COUNT; p++) begin
            if (page == page_t'(p))
               slot = slot_reg_i[2*p +: 2];
         end
      end
   end

   assign mem_req_o = '{
      slot:   slot,
      page:   page,
      offset: cycle_i.addr[13:0],
      wdata:  cycle_i.wdata,
      write:  cycle_i.is_write
   };

endmodule

//--- rtl/msx_audio_mix.sv
`timescale 1ns/1ps

module msx_audio_mix (
   input  logic                                    clk21m,
   input  logic                                    exwait_n,
   input  logic [msx_cfg_pkg::PSG_LEVEL_W-1:0]     psg_level_i,
   input  logic                                    keybeep_i,
   input  logic                                    cas_in_i,
   input  logic                                    cas_motor_i,
   input  logic signed [msx_cfg_pkg::CART_W-1:0]   cart_sound_i,
   output logic [15:0]                             audio_o
);
   import msx_cfg_pkg::*;

   logic [PSG_LEVEL_W:0]   base;
   logic [MIX_W-1:0]       mix;
   logic [15:0]            sample;

   // tape input is only heard while the motor bit is clear
   always_comb begin
      base = psg_level_i;
      if (keybeep_i)
         base = base + (PSG_LEVEL_W+1)'(BEEP_WEIGHT);
      if (cas_in_i && !cas_motor_i)
         base = base + (PSG_LEVEL_W+1)'(CAS_WEIGHT);
   end

   assign mix = {{(MIX_W - PSG_LEVEL_W - 5){1'b0}}, base, 4'b0000}
              + {{(MIX_W - CART_W){cart_sound_i[CART_W-1]}}, cart_sound_i};

   // top three bits equal means the doubled value still fits
   always_comb begin
      if (mix[MIX_W-1:MIX_W-3] == 3'b000 || mix[MIX_W-1:MIX_W-3] == 3'b111)
         sample = {mix[MIX_W-3:0], 1'b0};
      else if (mix[MIX_W-1])
         sample = AUDIO_MIN;
      else
         sample = AUDIO_MAX;
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n)
         audio_o <= '0;
      else
         audio_o <= sample;
   end

endmodule

//--- rtl/msx_core.sv
`timescale 1ns/1ps

module msx_core (
   input  logic                                    clk21m,
   input  logic                                    exwait_n,
   // cpu side
   input  logic                                    cpu_req_i,
   input  msx_bus_pkg::cpu_cycle_t                 cpu_cycle_i,
   output logic                                    cpu_ack_o,
   output logic [7:0]                              cpu_rdata_o,
   // external memory
   output logic                                    mem_req_o,
   output msx_bus_pkg::mem_req_t                   mem_req_data_o,
   input  logic                                    mem_ack_i,
   input  logic [7:0]                              mem_rdata_i,
   // external psg
   output logic                                    psg_req_o,
   output msx_bus_pkg::psg_req_t                   psg_req_data_o,
   input  logic                                    psg_ack_i,
   input  logic [7:0]                              psg_rdata_i,
   // keyboard, tape and sound
   input  logic [7:0]                              kb_cols_i,
   output logic [3:0]                              kb_row_o,
   input  logic                                    cas_in_i,
   output logic                                    cas_motor_o,
   input  logic [msx_cfg_pkg::PSG_LEVEL_W-1:0]     psg_level_i,
   input  logic signed [msx_cfg_pkg::CART_W-1:0]   cart_sound_i,
   output logic [15:0]                             audio_o
);
   import msx_bus_pkg::*;
   import msx_cfg_pkg::*;

   cpu_cycle_t              bus_cycle;
   mem_req_t                mem_payload;
   psg_req_t                psg_payload;
   logic                    io_stb;
   logic [7:0]              io_rdata;
   logic                    mem_start;
   logic                    psg_start;
   logic                    mem_done;
   logic                    psg_done;
   logic [7:0]              mem_rdata;
   logic [7:0]              psg_rdata;
   logic                    ext_done;
   logic [7:0]              ext_rdata;
   logic                    ppi_wr;
   logic [1:0]              ppi_sel;
   logic                    psg_hit;
   logic [7:0]              ppi_rdata;
   logic [2*PAGE_COUNT-1:0] slot_reg;
   logic                    map_valid;
   logic                    keybeep;

   // only one initiator is busy at a time
   assign ext_done  = mem_done | psg_done;
   assign ext_rdata = psg_hit ? psg_rdata : mem_rdata;

   assign psg_payload = '{
      reg_sel: bus_cycle.addr[0],
      write:   bus_cycle.is_write,
      data:    bus_cycle.wdata
   };

   msx_bus_ctrl u_bus_ctrl (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .cpu_req_i   (cpu_req_i),
      .cpu_cycle_i (cpu_cycle_i),
      .cpu_ack_o   (cpu_ack_o),
      .cpu_rdata_o (cpu_rdata_o),
      .cycle_o     (bus_cycle),
      .io_stb_o    (io_stb),
      .io_rdata_i  (io_rdata),
      .mem_start_o (mem_start),
      .psg_start_o (psg_start),
      .done_i      (ext_done),
      .ext_rdata_i (ext_rdata)
   );

   msx_io_decode u_io_decode (
      .cycle_i     (bus_cycle),
      .io_stb_i    (io_stb),
      .ppi_rdata_i (ppi_rdata),
      .ppi_wr_o    (ppi_wr),
      .ppi_sel_o   (ppi_sel),
      .psg_hit_o   (psg_hit),
      .io_rdata_o  (io_rdata)
   );

   msx_ppi u_ppi (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .sel_i       (ppi_sel),
      .wr_i        (ppi_wr),
      .wdata_i     (bus_cycle.wdata),
      .kb_cols_i   (kb_cols_i),
      .rdata_o     (ppi_rdata),
      .slot_reg_o  (slot_reg),
      .map_valid_o (map_valid),
      .kb_row_o    (kb_row_o),
      .cas_motor_o (cas_motor_o),
      .keybeep_o   (keybeep)
   );

   msx_slot_map u_slot_map (
      .cycle_i     (bus_cycle),
      .slot_reg_i  (slot_reg),
      .map_valid_i (map_valid),
      .mem_req_o   (mem_payload)
   );

   msx_hs_initiator #(.req_t(mem_req_t)) u_mem_hs (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .start_i   (mem_start),
      .payload_i (mem_payload),
      .rdata_i   (mem_rdata_i),
      .req_o     (mem_req_o),
      .payload_o (mem_req_data_o),
      .ack_i     (mem_ack_i),
      .done_o    (mem_done),
      .rdata_o   (mem_rdata)
   );

   msx_hs_initiator #(.req_t(psg_req_t)) u_psg_hs (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .start_i   (psg_start),
      .payload_i (psg_payload),
      .rdata_i   (psg_rdata_i),
      .req_o     (psg_req_o),
      .payload_o (psg_req_data_o),
      .ack_i     (psg_ack_i),
      .done_o    (psg_done),
      .rdata_o   (psg_rdata)
   );

   msx_audio_mix u_audio_mix (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .psg_level_i  (psg_level_i),
      .keybeep_i    (keybeep),
      .cas_in_i     (cas_in_i),
      .cas_motor_i  (cas_motor_o),
      .cart_sound_i (cart_sound_i),
      .audio_o      (audio_o)
   );

endmodule

//--- dv/msx_core_props.sv
`timescale 1ns/1ps

module msx_core_props (
   input logic                  clk21m,
   input logic                  exwait_n,
   input logic                  cpu_req_i,
   input logic                  cpu_ack_o,
   input logic                  mem_req_o,
   input msx_bus_pkg::mem_req_t mem_req_data_o,
   input logic                  mem_ack_i,
   input logic                  psg_req_o,
   input msx_bus_pkg::psg_req_t psg_req_data_o,
   input logic                  psg_ack_i
);

   int fails = 0;

   // ack only answers a pending request
   ack_needs_req: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $rose(cpu_ack_o) |-> $past(cpu_req_i))
   else begin
      fails++;
      $error("cpu_ack_o rose while cpu_req_i was low");
   end

   mem_payload_hold: assert property (@(posedge clk21m) disable iff (!exwait_n)
      mem_req_o && !mem_ack_i |=> $stable(mem_req_data_o))
   else begin
      fails++;
      $error("mem_req_data_o changed before mem_ack_i");
   end

   psg_payload_hold: assert property (@(posedge clk21m) disable iff (!exwait_n)
      psg_req_o && !psg_ack_i |=> $stable(psg_req_data_o))
   else begin
      fails++;
      $error("psg_req_data_o changed before psg_ack_i");
   end

   // a new request waits for the previous ack to drop
   mem_req_after_ack: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $rose(mem_req_o) |-> !$past(mem_ack_i))
   else begin
      fails++;
      $error("mem_req_o rose while mem_ack_i was still high");
   end

   psg_req_after_ack: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $rose(psg_req_o) |-> !$past(psg_ack_i))
   else begin
      fails++;
      $error("psg_req_o rose while psg_ack_i was still high");
   end

endmodule

bind msx_core msx_core_props u_props (.*);

//--- dv/msx_core_tb.sv
`timescale 1ns/1ps

module msx_core_tb;
   import msx_bus_pkg::*;
   import msx_cfg_pkg::*;

   localparam int LIMIT = 50;

   logic                     clk21m;
   logic                     exwait_n;
   logic                     cpu_req_i;
   cpu_cycle_t               cpu_cycle_i;
   logic                     cpu_ack_o;
   logic [7:0]               cpu_rdata_o;
   logic                     mem_req_o;
   mem_req_t                 mem_req_data_o;
   logic                     mem_ack_i;
   logic [7:0]               mem_rdata_i;
   logic                     psg_req_o;
   psg_req_t                 psg_req_data_o;
   logic                     psg_ack_i;
   logic [7:0]               psg_rdata_i;
   logic [7:0]               kb_cols_i;
   logic [3:0]               kb_row_o;
   logic                     cas_in_i;
   logic                     cas_motor_o;
   logic [PSG_LEVEL_W-1:0]   psg_level_i;
   logic signed [CART_W-1:0] cart_sound_i;
   logic [15:0]              audio_o;

   // four slots of 64k, indexed by slot, page, offset
   logic [7:0] mem [0:262143];
   logic [7:0] psg_regs [0:1];
   integer     seed = 52;
   int         mismatches = 0;
   int         timeouts = 0;
   logic       beep_on = 1'b0;
   logic       motor_on = 1'b0;

   // last cpu access
   logic [7:0] rd;
   int         ack_lat;
   int         req_lat;
   mem_req_t   seen_mem;
   psg_req_t   seen_psg;

   msx_core DUT (.*);

   // keyboard matrix answers with a byte built from the row
   assign kb_cols_i = cols_for_row(kb_row_o);

   function automatic logic [7:0] cols_for_row(input logic [3:0] row);
      return {row ^ 4'hA, ~row};
   endfunction

   function automatic logic [7:0] fill_byte(input logic [17:0] a);
      return a[7:0] ^ a[15:8] ^ {4{a[17:16]}} ^ 8'h5C;
   endfunction

   function automatic logic [15:0] expected_audio(input int lvl, input logic beep,
                                                  input logic cas, input logic motor,
                                                  input int cart);
      int base;
      int mix;
      base = lvl;
      if (beep)
         base = base + BEEP_WEIGHT;
      if (cas && !motor)
         base = base + CAS_WEIGHT;
      mix = base * 16 + cart;
      if (mix > 16383)
         return AUDIO_MAX;
      if (mix < -16384)
         return AUDIO_MIN;
      return 16'(mix * 2);
   endfunction

   task automatic next_cycle();
      @(posedge clk21m);
      #1;
   endtask

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else begin
         mismatches++;
         $display("MISMATCH @%0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout at %0t: %s never happened", $time, what);
   endtask

   // one four-phase cycle as the cpu side master
   task automatic cpu_access(input logic [15:0] addr, input logic [7:0] wdata,
                             input logic io, input logic wr, input logic m1);
      int n;
      cpu_cycle_i = '{addr: addr, wdata: wdata, is_io: io, is_write: wr,
                      is_m1: m1, spare: 1'b0};
      cpu_req_i = 1'b1;
      req_lat = 0;
      n = 0;
      while (!cpu_ack_o && n < LIMIT) begin
         next_cycle();
         n++;
         if (mem_req_o && req_lat == 0) begin
            req_lat = n;
            seen_mem = mem_req_data_o;
         end
         if (psg_req_o)
            seen_psg = psg_req_data_o;
      end
      if (!cpu_ack_o)
         report_timeout("cpu_ack_o rise");
      ack_lat = n;
      rd = cpu_rdata_o;
      cpu_req_i = 1'b0;
      n = 0;
      while (cpu_ack_o && n < LIMIT) begin
         next_cycle();
         n++;
      end
      if (cpu_ack_o)
         report_timeout("cpu_ack_o fall");
      check_eq("ack release latency", n, 1);
   endtask

   // ppi and unmapped ports are answered inside the core
   task automatic io_internal(input logic [7:0] port, input logic [7:0] data, input logic wr);
      cpu_access({8'h00, port}, data, 1'b1, wr, 1'b0);
      check_eq($sformatf("ack latency port %h", port), ack_lat, 2);
   endtask

   task automatic audio_case(input int lvl, input logic cas, input int cart);
      psg_level_i = lvl[PSG_LEVEL_W-1:0];
      cas_in_i = cas;
      cart_sound_i = cart[15:0];
      next_cycle();
      check_eq($sformatf("audio_o lvl %0d cart %0d", lvl, cart), audio_o,
               expected_audio(lvl, beep_on, cas, motor_on, cart));
   endtask

   initial begin
      clk21m = 1'b0;
      forever #50 clk21m = ~clk21m;
   end

   // memory answers after 1 to 4 cycles
   initial begin : memory_model
      int          a;
      int          delay;
      int          hold;
      int          n;
      logic [17:0] idx;
      mem_ack_i = 1'b0;
      mem_rdata_i = 8'h00;
      for (a = 0; a < 262144; a++)
         mem[a] = fill_byte(18'(a));
      forever begin
         next_cycle();
         if (mem_req_o && !mem_ack_i) begin
            delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (delay) next_cycle();
            idx = {mem_req_data_o.slot, mem_req_data_o.page, mem_req_data_o.offset};
            if (mem_req_data_o.write)
               mem[idx] = mem_req_data_o.wdata;
            mem_rdata_i = mem[idx];
            mem_ack_i = 1'b1;
            n = 0;
            while (mem_req_o && n < LIMIT) begin
               next_cycle();
               n++;
            end
            if (mem_req_o)
               report_timeout("mem_req_o release");
            // ack lingers a little after the request drops
            hold = $unsigned($random(seed)) % 3;
            repeat (hold) next_cycle();
            mem_ack_i = 1'b0;
         end
      end
   end

   initial begin : psg_model
      int n;
      psg_ack_i = 1'b0;
      psg_rdata_i = 8'h00;
      psg_regs[0] = 8'h00;
      psg_regs[1] = 8'h00;
      forever begin
         next_cycle();
         if (psg_req_o && !psg_ack_i) begin
            repeat (2) next_cycle();
            if (psg_req_data_o.write)
               psg_regs[psg_req_data_o.reg_sel] = psg_req_data_o.data;
            psg_rdata_i = psg_regs[psg_req_data_o.reg_sel];
            psg_ack_i = 1'b1;
            n = 0;
            while (psg_req_o && n < LIMIT) begin
               next_cycle();
               n++;
            end
            if (psg_req_o)
               report_timeout("psg_req_o release");
            // ack is released one cycle late
            next_cycle();
            psg_ack_i = 1'b0;
         end
      end
   end

   initial begin : stimulus
      logic [7:0]  slots;
      logic [15:0] addr;
      logic [17:0] idx;
      int          p;
      int          lat_plain;
      exwait_n = 1'b0;
      cpu_req_i = 1'b0;
      cpu_cycle_i = '0;
      cas_in_i = 1'b0;
      psg_level_i = '0;
      cart_sound_i = '0;
      repeat (2) @(posedge clk21m);
      #1;
      exwait_n = 1'b1;

      // idle state after reset
      check_eq("cpu_ack_o", cpu_ack_o, 0);
      check_eq("mem_req_o", mem_req_o, 0);
      check_eq("psg_req_o", psg_req_o, 0);
      check_eq("cas_motor_o", cas_motor_o, 0);
      check_eq("keybeep", DUT.keybeep, 0);
      check_eq("map_valid", DUT.map_valid, 0);
      check_eq("audio_o", audio_o, 0);
      for (p = 0; p < PAGE_COUNT; p++) begin
         addr = 16'(p * 16'h4000 + 16'h0100 + p * 16'h0111);
         cpu_access(addr, 8'h00, 1'b0, 1'b0, 1'b0);
         check_eq("slot before map", seen_mem.slot, 0);
         check_eq("page", seen_mem.page, p);
         check_eq("offset", seen_mem.offset, addr[13:0]);
         check_eq("reset read data", rd, fill_byte({2'b00, addr}));
      end

      // primary slot register
      slots = 8'hB4;
      io_internal(8'hA8, slots, 1'b1);
      io_internal(8'hA8, 8'h00, 1'b0);
      check_eq("port a8 readback", rd, slots);
      check_eq("map_valid", DUT.map_valid, 1);
      for (p = 0; p < PAGE_COUNT; p++) begin
         addr = 16'(p * 16'h4000 + 16'h2345);
         cpu_access(addr, 8'hC0 + 8'(p), 1'b0, 1'b1, 1'b0);
         check_eq($sformatf("slot of page %0d", p), seen_mem.slot, slots[2*p +: 2]);
         idx = {slots[2*p +: 2], addr};
         check_eq("memory content", mem[idx], 8'hC0 + 8'(p));
         cpu_access(addr, 8'h00, 1'b0, 1'b0, 1'b0);
         check_eq("mapped readback", rd, 8'hC0 + 8'(p));
      end

      // port c, row select and bit set/reset
      io_internal(8'hAA, 8'h05, 1'b1);
      check_eq("kb_row_o", kb_row_o, 5);
      io_internal(8'hA9, 8'h00, 1'b0);
      check_eq("keyboard columns", rd, cols_for_row(4'h5));
      io_internal(8'hAB, 8'h09, 1'b1);
      check_eq("cas_motor_o set", cas_motor_o, 1);
      io_internal(8'hAB, 8'h0F, 1'b1);
      check_eq("keybeep set", DUT.keybeep, 1);
      // mode word must not touch port c
      io_internal(8'hAB, 8'h89, 1'b1);
      check_eq("cas_motor_o after mode word", cas_motor_o, 1);
      io_internal(8'hAA, 8'h00, 1'b0);
      check_eq("port c readback", rd, 8'h95);
      io_internal(8'hAB, 8'h08, 1'b1);
      check_eq("cas_motor_o clear", cas_motor_o, 0);
      check_eq("kb_row_o kept", kb_row_o, 5);
      beep_on = 1'b1;
      motor_on = 1'b0;

      // unmapped port and psg
      io_internal(8'h98, 8'h00, 1'b0);
      check_eq("unmapped read", rd, 8'hFF);
      cpu_access(16'h00A0, 8'h07, 1'b1, 1'b1, 1'b0);
      check_eq("psg write payload", seen_psg, {1'b0, 1'b1, 8'h07});
      cpu_access(16'h00A1, 8'h3C, 1'b1, 1'b1, 1'b0);
      check_eq("psg data payload", seen_psg, {1'b1, 1'b1, 8'h3C});
      cpu_access(16'h00A2, 8'h00, 1'b1, 1'b0, 1'b0);
      check_eq("psg read reg 0", rd, 8'h07);
      cpu_access(16'h00A3, 8'h00, 1'b1, 1'b0, 1'b0);
      check_eq("psg read reg 1", rd, 8'h3C);

      // opcode fetch wait cycle
      cpu_access(16'h8010, 8'h00, 1'b0, 1'b0, 1'b0);
      lat_plain = req_lat;
      check_eq("plain mem_req_o latency", lat_plain, 2);
      cpu_access(16'h8010, 8'h00, 1'b0, 1'b0, 1'b1);
      check_eq("m1 mem_req_o latency", req_lat, lat_plain + 1);

      // audio mixer with beep on, motor off
      audio_case(300, 1'b1, -1000);
      audio_case(0, 1'b0, 0);
      // full psg level plus beep and tape goes past ten bits
      audio_case(1023, 1'b1, -16000);
      io_internal(8'hAB, 8'h0E, 1'b1);
      beep_on = 1'b0;
      audio_case(100, 1'b1, 5);
      audio_case(0, 1'b0, 16383);
      audio_case(0, 1'b0, -16384);
      audio_case(1000, 1'b0, 20000);
      audio_case(0, 1'b0, -30000);
      audio_case(1023, 1'b0, 16383);
      io_internal(8'hAB, 8'h09, 1'b1);
      motor_on = 1'b1;
      audio_case(100, 1'b1, 0);

      repeat (2) next_cycle();
      $display("checks done: %0d mismatches, %0d timeouts, %0d property failures",
               mismatches, timeouts, DUT.u_props.fails);
      if (mismatches == 0 && timeouts == 0 && DUT.u_props.fails == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- sim.f
rtl/msx_bus_pkg.sv
rtl/msx_cfg_pkg.sv
rtl/msx_hs_initiator.sv
rtl/msx_bus_ctrl.sv
rtl/msx_io_decode.sv
rtl/msx_ppi.sv
rtl/msx_slot_map.sv
rtl/msx_audio_mix.sv
rtl/msx_core.sv
dv/msx_core_props.sv
dv/msx_core_tb.sv

//--- Bender.yml
package:
  name: msx_core

sources:
  - files:
      - rtl/msx_bus_pkg.sv
      - rtl/msx_cfg_pkg.sv
      - rtl/msx_hs_initiator.sv
      - rtl/msx_bus_ctrl.sv
      - rtl/msx_io_decode.sv
      - rtl/msx_ppi.sv
      - rtl/msx_slot_map.sv
      - rtl/msx_audio_mix.sv
      - rtl/msx_core.sv
  - target: test
    files:
      - dv/msx_core_props.sv
      - dv/msx_core_tb.sv
